// ==== project.f ====
source/dcache_pkg.sv
source/dcache_lookup.sv
source/dcache_tag_store.sv
source/dcache_data_array.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/tb_mem_model.sv
verification/tb_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dcache -Mdir obj_dir -o tb_dcache_sim \
    -f project.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/tb_dcache_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit "$run_status"
fi

echo "simulation finished with status 0"
exit 0

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    capture_i,
    input  dcache_addr_t            req_addr_i,
    input  logic [DATA_W-1:0]       req_wdata_i,
    input  logic [MASK_W-1:0]       req_mask_i,
    input  logic                    req_store_i,
    input  logic                    hit_i,
    input  logic                    hit_way_i,
    input  tag_t [1:0]              way_tag_i,
    input  logic [1:0]              way_valid_i,
    input  logic [1:0]              way_dirty_i,
    input  logic                    lru_way_i,
    input  logic [1:0][DATA_W-1:0]  way_data_i,
    input  logic                    mem_ok_i,
    input  logic [DATA_W-1:0]       mem_rdata_i,
    output logic                    accept_o,
    output logic                    tag_wr_en_o,
    output logic                    tag_wr_way_o,
    output logic                    set_dirty_o,
    output logic                    clr_dirty_o,
    output logic                    touch_o,
    output logic                    touch_way_o,
    output logic                    data_wr_way_o,
    output logic [MASK_W-1:0]       data_wr_be_o,
    output logic [DATA_W-1:0]       data_wr_data_o,
    output logic [DATA_W-1:0]       rdata_o,
    output logic                    done_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output dcache_addr_t            mem_addr_o,
    output logic [DATA_W-1:0]       mem_wdata_o
);

    ctrl_state_t        state_q;
    ctrl_state_t        state_d;
    logic               victim_d;
    logic               victim_q;
    tag_t               vic_tag_q;
    logic [DATA_W-1:0]  vic_data_q;
    logic [DATA_W-1:0]  fill_q;
    logic [DATA_W-1:0]  fill_data;
    logic [DATA_W-1:0]  rdata_q;
    logic               line_way;
    dcache_addr_t       wb_addr;
    dcache_addr_t       fill_addr;

    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_w,
        input logic [DATA_W-1:0] new_w,
        input logic [MASK_W-1:0] be
    );
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < MASK_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // empty way first, then the least recently used one
    always_comb begin
        if (!way_valid_i[0]) begin
            victim_d = 1'b0;
        end else if (!way_valid_i[1]) begin
            victim_d = 1'b1;
        end else begin
            victim_d = lru_way_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:   if (capture_i) state_d = LOOKUP;
            LOOKUP: begin
                if (hit_i) begin
                    state_d = HIT;
                end else if (way_valid_i[victim_d] && way_dirty_i[victim_d]) begin
                    state_d = WBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            HIT:    state_d = DONE;
            WBACK:  if (mem_ok_i) state_d = REFILL;
            REFILL: if (mem_ok_i) state_d = FILL;
            FILL:   state_d = DONE;
            // extra cycle keeps a held request from being taken twice
            DONE:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // victim snapshot and refill word
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            victim_q   <= victim_d;
            vic_tag_q  <= way_tag_i[victim_d];
            vic_data_q <= way_data_i[victim_d];
        end
        if (state_q == REFILL && mem_ok_i) begin
            fill_q <= mem_rdata_i;
        end
        if (state_q == HIT) begin
            rdata_q <= way_data_i[hit_way_i];
        end else if (state_q == FILL) begin
            rdata_q <= fill_data;
        end
    end

    // refill word with the store bytes on top
    assign fill_data = req_store_i ? merge_bytes(fill_q, req_wdata_i, req_mask_i) : fill_q;

    assign line_way = (state_q == HIT) ? hit_way_i : victim_q;

    assign accept_o     = (state_q == IDLE);
    assign tag_wr_en_o  = (state_q == FILL);
    assign tag_wr_way_o = line_way;
    assign set_dirty_o  = req_store_i && ((state_q == HIT) || (state_q == FILL));
    // new line goes in clean unless a store lands in it
    assign clr_dirty_o  = !req_store_i && (state_q == FILL);
    assign touch_o      = (state_q == HIT) || (state_q == FILL);
    assign touch_way_o  = line_way;

    assign data_wr_way_o  = line_way;
    assign data_wr_be_o   = (state_q == FILL) ? '1 :
                            ((state_q == HIT) && req_store_i) ? req_mask_i : '0;
    assign data_wr_data_o = (state_q == HIT) ? req_wdata_i : fill_data;

    assign rdata_o = rdata_q;
    assign done_o  = (state_q == DONE);

    // write-back address comes from the victim tag, not the request
    always_comb begin
        wb_addr.raw        = '0;
        wb_addr.f.tag      = vic_tag_q;
        wb_addr.f.index    = req_addr_i.f.index;
        fill_addr.raw      = req_addr_i.raw;
        fill_addr.f.offset = '0;
    end

    assign mem_rd_o       = (state_q == REFILL);
    assign mem_wr_o       = (state_q == WBACK);
    assign mem_addr_o.raw = (state_q == WBACK) ? wb_addr.raw : fill_addr.raw;
    assign mem_wdata_o    = vic_data_q;

    // address held until memory answers
    a_mem_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        ((mem_rd_o || mem_wr_o) && !mem_ok_i) |=> $stable(mem_addr_o.raw));

endmodule

`default_nettype wire

// ==== source/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array import dcache_pkg::*; (
    input  logic                    clk,
    input  index_t                  rd_index_i,
    input  logic                    wr_way_i,
    input  index_t                  wr_index_i,
    input  logic [MASK_W-1:0]       wr_be_i,
    input  logic [DATA_W-1:0]       wr_data_i,
    output logic [1:0][DATA_W-1:0]  way_data_o
);

    // one word per set per way, written bytewise
    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [DATA_W-1:0] mem [NUM_SETS];
        logic              sel;

        assign sel = (wr_way_i == 1'(w));

        always_ff @(posedge clk) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (sel && wr_be_i[b]) begin
                    mem[wr_index_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
            // read before write on the same set
            way_data_o[w] <= mem[rd_index_i];
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup import dcache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_i,
    input  logic               wr_i,
    input  dcache_addr_t       addr_i,
    input  logic [DATA_W-1:0]  wdata_i,
    input  logic [MASK_W-1:0]  mask_i,
    input  logic               accept_i,
    input  tag_t [1:0]         way_tag_i,
    input  logic [1:0]         way_valid_i,
    output logic               capture_o,
    output dcache_addr_t       req_addr_o,
    output logic [DATA_W-1:0]  req_wdata_o,
    output logic [MASK_W-1:0]  req_mask_o,
    output logic               req_store_o,
    output logic               hit_o,
    output logic               hit_way_o
);

    dcache_addr_t       req_addr_q;
    logic [DATA_W-1:0]  req_wdata_q;
    logic [MASK_W-1:0]  req_mask_q;
    logic               req_store_q;
    tag_t               req_tag;
    logic [1:0]         way_hit;

    // controller idle and a request present
    assign capture_o = accept_i && (rd_i || wr_i);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_store_q <= 1'b0;
        end else if (capture_o) begin
            req_store_q <= wr_i;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (capture_o) begin
            req_addr_q.raw <= addr_i.raw;
            req_wdata_q    <= wdata_i;
            req_mask_q     <= mask_i;
        end
    end

    assign req_tag = req_addr_q.f.tag;

    // arrays were read with the same index at the capture edge
    assign way_hit[0] = way_valid_i[0] && (way_tag_i[0] == req_tag);
    assign way_hit[1] = way_valid_i[1] && (way_tag_i[1] == req_tag);

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    assign req_addr_o  = req_addr_q;
    assign req_wdata_o = req_wdata_q;
    assign req_mask_o  = req_mask_q;
    assign req_store_o = req_store_q;

    // one controller serves both directions
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst)
        !(rd_i && wr_i));

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int MASK_W   = DATA_W / 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // raw word for the memory bus, fields for the arrays
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            tag_t                tag;
            index_t              index;
            logic [OFFSET_W-1:0] offset;
        } f;
    } dcache_addr_t;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        HIT    = 3'd2,
        WBACK  = 3'd3,
        REFILL = 3'd4,
        FILL   = 3'd5,
        DONE   = 3'd6
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/dcache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  index_t      rd_index_i,
    input  logic        wr_en_i,
    input  logic        wr_way_i,
    input  index_t      wr_index_i,
    input  tag_t        wr_tag_i,
    input  logic        set_dirty_i,
    input  logic        clr_dirty_i,
    input  logic        touch_i,
    input  logic        touch_way_i,
    output tag_t [1:0]  way_tag_o,
    output logic [1:0]  way_valid_o,
    output logic [1:0]  way_dirty_o,
    output logic        lru_way_o
);

    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]      lru_q;

    // tag arrays, one per way
    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t tag_mem [NUM_SETS];

        always_ff @(posedge clk) begin
            if (wr_en_i && (wr_way_i == 1'(w))) begin
                tag_mem[wr_index_i] <= wr_tag_i;
            end
            way_tag_o[w] <= tag_mem[rd_index_i];
        end
    end

    // state bits per set
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (wr_en_i) begin
                valid_q[wr_way_i][wr_index_i] <= 1'b1;
            end
            if (set_dirty_i) begin
                dirty_q[wr_way_i][wr_index_i] <= 1'b1;
            end else if (clr_dirty_i) begin
                dirty_q[wr_way_i][wr_index_i] <= 1'b0;
            end
            // other way becomes the replacement candidate
            if (touch_i) begin
                lru_q[wr_index_i] <= ~touch_way_i;
            end
        end
    end

    // read side, one cycle behind the index like the tag arrays
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way_valid_o <= '0;
            way_dirty_o <= '0;
            lru_way_o   <= 1'b0;
        end else begin
            way_valid_o[0] <= valid_q[0][rd_index_i];
            way_valid_o[1] <= valid_q[1][rd_index_i];
            way_dirty_o[0] <= dirty_q[0][rd_index_i];
            way_dirty_o[1] <= dirty_q[1][rd_index_i];
            lru_way_o      <= lru_q[rd_index_i];
        end
    end

    // set and clear both target the same set and way
    a_dirty_excl: assert property (@(posedge clk) disable iff (!rst)
        !(set_dirty_i && clr_dirty_i));

    // only a resident or just installed line can turn dirty
    a_dirty_valid: assert property (@(posedge clk) disable iff (!rst)
        set_dirty_i |-> (wr_en_i || valid_q[wr_way_i][wr_index_i]));

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_i,
    input  logic               wr_i,
    input  dcache_addr_t       addr_i,
    input  logic [DATA_W-1:0]  wdata_i,
    input  logic [MASK_W-1:0]  mask_i,
    output logic [DATA_W-1:0]  rdata_o,
    output logic               done_o,
    output logic               mem_rd_o,
    output logic               mem_wr_o,
    output dcache_addr_t       mem_addr_o,
    output logic [DATA_W-1:0]  mem_wdata_o,
    input  logic               mem_ok_i,
    input  logic [DATA_W-1:0]  mem_rdata_i
);

    // registered request
    dcache_addr_t              req_addr;
    logic [DATA_W-1:0]         req_wdata;
    logic [MASK_W-1:0]         req_mask;
    logic                      req_store;
    logic                      capture;
    logic                      accept;
    logic                      hit;
    logic                      hit_way;

    // array read side
    tag_t [1:0]                way_tag;
    logic [1:0]                way_valid;
    logic [1:0]                way_dirty;
    logic                      lru_way;
    logic [1:0][DATA_W-1:0]    way_data;

    // array write side
    logic                      tag_wr_en;
    logic                      tag_wr_way;
    logic                      set_dirty;
    logic                      clr_dirty;
    logic                      touch;
    logic                      touch_way;
    logic                      data_wr_way;
    logic [MASK_W-1:0]         data_wr_be;
    logic [DATA_W-1:0]         data_wr_data;

    dcache_lookup u_lookup (
        .clk         (clk),
        .rst         (rst),
        .rd_i        (rd_i),
        .wr_i        (wr_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .mask_i      (mask_i),
        .accept_i    (accept),
        .way_tag_i   (way_tag),
        .way_valid_i (way_valid),
        .capture_o   (capture),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .req_mask_o  (req_mask),
        .req_store_o (req_store),
        .hit_o       (hit),
        .hit_way_o   (hit_way)
    );

    // arrays are indexed by the incoming address, held by the core until done
    dcache_tag_store u_tags (
        .clk         (clk),
        .rst         (rst),
        .rd_index_i  (addr_i.f.index),
        .wr_en_i     (tag_wr_en),
        .wr_way_i    (tag_wr_way),
        .wr_index_i  (req_addr.f.index),
        .wr_tag_i    (req_addr.f.tag),
        .set_dirty_i (set_dirty),
        .clr_dirty_i (clr_dirty),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .way_tag_o   (way_tag),
        .way_valid_o (way_valid),
        .way_dirty_o (way_dirty),
        .lru_way_o   (lru_way)
    );

    dcache_data_array u_data (
        .clk        (clk),
        .rd_index_i (addr_i.f.index),
        .wr_way_i   (data_wr_way),
        .wr_index_i (req_addr.f.index),
        .wr_be_i    (data_wr_be),
        .wr_data_i  (data_wr_data),
        .way_data_o (way_data)
    );

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .capture_i      (capture),
        .req_addr_i     (req_addr),
        .req_wdata_i    (req_wdata),
        .req_mask_i     (req_mask),
        .req_store_i    (req_store),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .way_tag_i      (way_tag),
        .way_valid_i    (way_valid),
        .way_dirty_i    (way_dirty),
        .lru_way_i      (lru_way),
        .way_data_i     (way_data),
        .mem_ok_i       (mem_ok_i),
        .mem_rdata_i    (mem_rdata_i),
        .accept_o       (accept),
        .tag_wr_en_o    (tag_wr_en),
        .tag_wr_way_o   (tag_wr_way),
        .set_dirty_o    (set_dirty),
        .clr_dirty_o    (clr_dirty),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .data_wr_way_o  (data_wr_way),
        .data_wr_be_o   (data_wr_be),
        .data_wr_data_o (data_wr_data),
        .rdata_o        (rdata_o),
        .done_o         (done_o),
        .mem_rd_o       (mem_rd_o),
        .mem_wr_o       (mem_wr_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o)
    );

    // compare result must still hold one cycle after lookup
    a_hit_held: assert property (@(posedge clk) disable iff (!rst)
        (u_ctrl.state_q == HIT) |-> hit);

endmodule

`default_nettype wire

// ==== verification/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int SEED         = 33;
    localparam int MEM_LAT      = 4;
    localparam int MEM_WORDS    = 1024;
    localparam int DONE_TIMEOUT = 200;
    localparam int RAND_OPS     = 300;

    logic               clk;
    logic               rst;
    logic               rd;
    logic               wr;
    dcache_addr_t       addr;
    logic [DATA_W-1:0]  wdata;
    logic [MASK_W-1:0]  mask;
    logic [DATA_W-1:0]  rdata;
    logic               done;
    logic               mem_rd;
    logic               mem_wr;
    dcache_addr_t       mem_addr;
    logic [DATA_W-1:0]  mem_wdata;
    logic               mem_ok;
    logic [DATA_W-1:0]  mem_rdata;
    logic [31:0]        rd_count;
    logic [31:0]        wr_count;
    logic [63:0]        last_wr_addr;
    logic [63:0]        last_wr_data;

    // expected memory image with the cache's dirty words folded in
    logic [DATA_W-1:0]  shadow [MEM_WORDS];
    logic [DATA_W-1:0]  exp_rdata;
    logic               load_pending;
    int                 loads_issued;
    int                 loads_checked;
    int                 latency;
    bit                 mem_ops [$];
    logic               prev_mem_rd;
    logic               prev_mem_wr;

    dcache_top uut (
        .clk         (clk),
        .rst         (rst),
        .rd_i        (rd),
        .wr_i        (wr),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .mask_i      (mask),
        .rdata_o     (rdata),
        .done_o      (done),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ok_i    (mem_ok),
        .mem_rdata_i (mem_rdata)
    );

    tb_mem_model #(.MAX_LAT(MEM_LAT), .MEM_WORDS(MEM_WORDS)) u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_rd_i       (mem_rd),
        .mem_wr_i       (mem_wr),
        .mem_addr_i     (mem_addr.raw),
        .mem_wdata_i    (mem_wdata),
        .mem_ok_o       (mem_ok),
        .mem_rdata_o    (mem_rdata),
        .rd_count_o     (rd_count),
        .wr_count_o     (wr_count),
        .last_wr_addr_o (last_wr_addr),
        .last_wr_data_o (last_wr_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [DATA_W-1:0] preload_word(input int unsigned w);
        return {w ^ 32'hC3A5_5A3C, w * 32'h9E37_79B9};
    endfunction

    function automatic dcache_addr_t make_addr(input int unsigned tag, input int unsigned index);
        dcache_addr_t a;
        a.raw     = '0;
        a.f.tag   = tag_t'(tag);
        a.f.index = index_t'(index);
        return a;
    endfunction

    function automatic int unsigned word_of(input dcache_addr_t a);
        return 32'(a.raw[12:3]);
    endfunction

    // load returns the stored word, store merges its masked bytes
    function automatic logic [DATA_W-1:0] ref_access(input logic store, input dcache_addr_t a,
                                                     input logic [DATA_W-1:0] d,
                                                     input logic [MASK_W-1:0] be);
        logic [DATA_W-1:0] word;
        word = shadow[word_of(a)];
        if (store) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (be[b]) begin
                    word[8*b +: 8] = d[8*b +: 8];
                end
            end
            shadow[word_of(a)] = word;
        end
        return word;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    // one request held until done, latency counted from the sampling edge
    task automatic cache_access(input logic store, input dcache_addr_t a,
                                input logic [DATA_W-1:0] d, input logic [MASK_W-1:0] be);
        logic [DATA_W-1:0] expected;
        int                cycles;
        expected = ref_access(store, a, d, be);
        @(negedge clk);
        rd    = !store;
        wr    = store;
        addr  = a;
        wdata = d;
        mask  = be;
        if (!store) begin
            exp_rdata    = expected;
            load_pending = 1'b1;
            loads_issued++;
        end
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            cycles++;
            if (cycles >= DONE_TIMEOUT) begin
                stop_with_failure($sformatf("cache gave no done_o within %0d cycles", cycles));
            end else begin
                @(negedge clk);
            end
        end
        latency = cycles;
        @(negedge clk);
        rd = 1'b0;
        wr = 1'b0;
    endtask

    // load data is compared while done_o is high
    always @(negedge clk) begin
        if (rst && done && load_pending) begin
            check_eq("rdata_o", rdata, exp_rdata);
            load_pending = 1'b0;
            loads_checked++;
        end
    end

    // order of memory requests, one entry per raised level
    always @(negedge clk) begin
        if (rst && mem_wr && !prev_mem_wr) begin
            mem_ops.push_back(1'b1);
        end
        if (rst && mem_rd && !prev_mem_rd) begin
            mem_ops.push_back(1'b0);
        end
        prev_mem_wr = mem_wr;
        prev_mem_rd = mem_rd;
    end

    initial begin
        dcache_addr_t       a;
        logic [DATA_W-1:0]  d;
        logic               is_store;
        logic [31:0]        rd_before;
        logic [31:0]        wr_before;

        void'($urandom(SEED));
        rst           = 1'b0;
        rd            = 1'b0;
        wr            = 1'b0;
        addr.raw      = '0;
        wdata         = '0;
        mask          = '0;
        load_pending  = 1'b0;
        loads_issued  = 0;
        loads_checked = 0;
        latency       = 0;
        prev_mem_rd   = 1'b0;
        prev_mem_wr   = 1'b0;
        for (int unsigned w = 0; w < MEM_WORDS; w++) begin
            shadow[w] = preload_word(w);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_eq("done_o", 64'(done), 64'd0);
        check_eq("mem_rd_o", 64'(mem_rd), 64'd0);
        check_eq("mem_wr_o", 64'(mem_wr), 64'd0);

        // first load comes from memory
        rd_before = rd_count;
        cache_access(1'b0, make_addr(1, 5), '0, '0);
        check_eq("mem read count", 64'(rd_count), 64'(rd_before + 32'd1));

        // repeated load hits with fixed latency and no traffic
        rd_before = rd_count;
        wr_before = wr_count;
        cache_access(1'b0, make_addr(1, 5), '0, '0);
        check_eq("hit latency", 64'(latency), 64'd2);
        check_eq("mem read count", 64'(rd_count), 64'(rd_before));
        check_eq("mem write count", 64'(wr_count), 64'(wr_before));

        // partial store on a hit, then on a miss
        cache_access(1'b1, make_addr(1, 5), {$urandom, $urandom}, 8'b0010_1101);
        check_eq("store hit latency", 64'(latency), 64'd2);
        cache_access(1'b0, make_addr(1, 5), '0, '0);
        rd_before = rd_count;
        cache_access(1'b1, make_addr(2, 9), {$urandom, $urandom}, 8'hC3);
        check_eq("mem read count", 64'(rd_count), 64'(rd_before + 32'd1));
        cache_access(1'b0, make_addr(2, 9), '0, '0);

        // tag 3 ends up least recently used and dirty
        cache_access(1'b1, make_addr(3, 20), {$urandom, $urandom}, 8'hFF);
        cache_access(1'b1, make_addr(4, 20), {$urandom, $urandom}, 8'h0F);
        wr_before = wr_count;
        mem_ops.delete();
        cache_access(1'b0, make_addr(5, 20), '0, '0);
        a = make_addr(3, 20);
        check_eq("mem write count", 64'(wr_count), 64'(wr_before + 32'd1));
        check_eq("write-back addr", last_wr_addr, a.raw);
        check_eq("write-back data", last_wr_data, shadow[word_of(a)]);
        check_eq("mem request count", 64'(mem_ops.size()), 64'd2);
        check_eq("first mem request is write", 64'(mem_ops[0]), 64'd1);
        check_eq("second mem request is read", 64'(mem_ops[1]), 64'd0);
        cache_access(1'b0, make_addr(4, 20), '0, '0);
        check_eq("hit latency", 64'(latency), 64'd2);

        // random mix over the top four sets
        for (int n = 0; n < RAND_OPS; n++) begin
            is_store = 1'($urandom_range(1, 0));
            a        = make_addr($urandom_range(7, 0), $urandom_range(63, 60));
            d        = {$urandom, $urandom};
            cache_access(is_store, a, d, 8'($urandom));
        end

        // two fresh tags per set push every dirty line out
        for (int unsigned s = 0; s < NUM_SETS; s++) begin
            cache_access(1'b0, make_addr(14, s), '0, '0);
            cache_access(1'b0, make_addr(15, s), '0, '0);
        end
        check_eq("loads checked", 64'(loads_checked), 64'(loads_issued));
        for (int w = 0; w < MEM_WORDS; w++) begin
            check_eq($sformatf("mem[%0d]", w), u_mem.mem[w], shadow[w]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter int MAX_LAT   = 4,
    parameter int MEM_WORDS = 1024
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         mem_rd_i,
    input  logic         mem_wr_i,
    input  logic [63:0]  mem_addr_i,
    input  logic [63:0]  mem_wdata_i,
    output logic         mem_ok_o,
    output logic [63:0]  mem_rdata_o,
    output logic [31:0]  rd_count_o,
    output logic [31:0]  wr_count_o,
    output logic [63:0]  last_wr_addr_o,
    output logic [63:0]  last_wr_data_o
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [63:0]    mem [MEM_WORDS];
    logic           busy;
    int             delay;
    logic [AW-1:0]  word;

    assign word = mem_addr_i[3 +: AW];

    // fill pattern covers every word address
    initial begin
        for (int unsigned i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= {i ^ 32'hC3A5_5A3C, i * 32'h9E37_79B9};
        end
        mem_ok_o    <= 1'b0;
        mem_rdata_o <= '0;
    end

    // ok answers a held level after a random wait, then drops
    always @(negedge clk or negedge rst) begin
        if (!rst) begin
            mem_ok_o       <= 1'b0;
            mem_rdata_o    <= '0;
            busy           <= 1'b0;
            delay          <= 0;
            rd_count_o     <= '0;
            wr_count_o     <= '0;
            last_wr_addr_o <= '0;
            last_wr_data_o <= '0;
        end else if (mem_ok_o) begin
            mem_ok_o <= 1'b0;
        end else if (mem_rd_i || mem_wr_i) begin
            if (!busy) begin
                busy  <= 1'b1;
                delay <= int'($urandom_range(MAX_LAT, 0));
            end else if (delay != 0) begin
                delay <= delay - 1;
            end else begin
                busy     <= 1'b0;
                mem_ok_o <= 1'b1;
                if (mem_wr_i) begin
                    mem[word]      <= mem_wdata_i;
                    wr_count_o     <= wr_count_o + 32'd1;
                    last_wr_addr_o <= mem_addr_i;
                    last_wr_data_o <= mem_wdata_i;
                end else begin
                    mem_rdata_o <= mem[word];
                    rd_count_o  <= rd_count_o + 32'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
